// File: design/alu.sv
`timescale 1ns/1ps

module alu
  import mips_ex_pkg::*;
(
  input  word_t   i_a,                     // Operand A, also shift amount
  input  word_t   i_b,                     // Operand B, value to shift
  input  alu_op_t i_op,
  output word_t   o_result
);

  logic [4:0] shamt;                       // Low five bits of A
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = i_a[4:0];
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_OR:     o_result = i_a | i_b;
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_NOR:    o_result = ~(i_a | i_b);
      ALU_SLT:    o_result = {{(DATA_W-1){1'b0}}, lt_signed};   // 0 or 1
      ALU_SLTU:   o_result = {{(DATA_W-1){1'b0}}, lt_unsigned};
      ALU_SLL:    o_result = i_b << shamt;
      ALU_SRL:    o_result = i_b >> shamt;
      ALU_SRA:    o_result = word_t'($signed(i_b) >>> shamt);   // Keep sign
      ALU_LUI:    o_result = {i_b[15:0], 16'h0000};
      ALU_PASS_A: o_result = i_a;
      default:    o_result = i_a + i_b;
    endcase
  end

endmodule

// File: design/alu_control.sv
`timescale 1ns/1ps

module alu_control
  import mips_ex_pkg::*;
(
  input  opcode_t i_opcode,                // Instruction opcode
  input  funct_t  i_funct,                 // Only meaningful for R-type
  output alu_op_t o_alu_op                 // Operation for the ALU
);

  // R-type function decode
  alu_op_t rtype_op;

  always_comb begin
    case (i_funct)
      FN_ADDU:                  rtype_op = ALU_ADD;
      FN_SUBU:                  rtype_op = ALU_SUB;
      FN_AND:                   rtype_op = ALU_AND;
      FN_OR:                    rtype_op = ALU_OR;
      FN_XOR:                   rtype_op = ALU_XOR;
      FN_NOR:                   rtype_op = ALU_NOR;
      FN_SLT:                   rtype_op = ALU_SLT;
      FN_SLTU:                  rtype_op = ALU_SLTU;
      FN_SLL, FN_SLLV:          rtype_op = ALU_SLL;    // Amount via operand A
      FN_SRL, FN_SRLV:          rtype_op = ALU_SRL;
      FN_SRA, FN_SRAV:          rtype_op = ALU_SRA;
      FN_JALR:                  rtype_op = ALU_PASS_A; // Link PC+4
      default:                  rtype_op = ALU_ADD;
    endcase
  end

  // Opcode decode
  always_comb begin
    case (i_opcode)
      OP_RTYPE:         o_alu_op = rtype_op;
      OP_ADDIU:         o_alu_op = ALU_ADD;
      OP_ANDI:          o_alu_op = ALU_AND;
      OP_ORI:           o_alu_op = ALU_OR;
      OP_XORI:          o_alu_op = ALU_XOR;
      OP_SLTI:          o_alu_op = ALU_SLT;
      OP_SLTIU:         o_alu_op = ALU_SLTU;
      OP_LUI:           o_alu_op = ALU_LUI;
      OP_LW, OP_SW:     o_alu_op = ALU_ADD;               // Base plus offset
      OP_JAL:           o_alu_op = ALU_PASS_A;
      default:          o_alu_op = ALU_ADD;
    endcase
  end

endmodule

// File: design/ex_mem_wb_regs.sv
`timescale 1ns/1ps

module ex_mem_wb_regs
  import mips_ex_pkg::*;
(
  input  logic      clk,
  input  logic      i_arst_n,
  input  logic      i_valid,               // From EX, already gated
  input  word_t     i_alu_result,
  input  word_t     i_store_data,
  input  reg_addr_t i_write_reg,
  input  logic      i_reg_write,
  input  logic      i_mem_read,
  input  logic      i_mem_write,
  input  logic      i_mem_to_reg,
  input  word_t     i_mem_rdata,           // Combinational read data
  output logic      o_exm_valid,
  output reg_addr_t o_exm_reg,
  output logic      o_exm_write,           // To forwarding, loads excluded
  output word_t     o_exm_result,
  output word_t     o_mem_addr,
  output word_t     o_mem_wdata,
  output logic      o_mem_read,
  output logic      o_mem_write,
  output logic      o_wb_write,
  output reg_addr_t o_wb_reg,
  output word_t     o_wb_data
);

  logic exm_reg_write;
  logic exm_mem_to_reg;

  // --------------------------------------------------------------------------
  // EX/MEM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_exm_valid    <= 1'b0;
      exm_reg_write  <= 1'b0;
      o_mem_read     <= 1'b0;
      o_mem_write    <= 1'b0;
      exm_mem_to_reg <= 1'b0;
    end else begin
      o_exm_valid    <= i_valid;
      exm_reg_write  <= i_reg_write;
      o_mem_read     <= i_mem_read;
      o_mem_write    <= i_mem_write;
      exm_mem_to_reg <= i_mem_to_reg;
    end
  end

  always_ff @(posedge clk) begin
    o_exm_result <= i_alu_result;          // Also the memory address
    o_mem_wdata  <= i_store_data;
    o_exm_reg    <= i_write_reg;
  end

  assign o_mem_addr  = o_exm_result;
  assign o_exm_write = exm_reg_write & ~exm_mem_to_reg;  // Load data not here yet

  // MEM/WB
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_write <= 1'b0;
    end else begin
      o_wb_write <= exm_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_reg  <= o_exm_reg;
    o_wb_data <= exm_mem_to_reg ? i_mem_rdata : o_exm_result;  // Load merge
  end

endmodule

// File: design/ex_pipe_top.sv
`timescale 1ns/1ps

module ex_pipe_top
  import mips_ex_pkg::*;
(
  input  logic      clk,
  input  logic      i_arst_n,
  input  logic      i_valid,               // Decode side
  input  logic      i_stall,
  input  logic      i_flush,
  input  word_t     i_read_data_1,
  input  word_t     i_read_data_2,
  input  word_t     i_imm,
  input  word_t     i_shamt,
  input  word_t     i_next_pc,
  input  reg_addr_t i_rs,
  input  reg_addr_t i_rt,
  input  reg_addr_t i_rd,
  input  opcode_t   i_opcode,
  input  funct_t    i_funct,
  input  src_a_t    i_alu_src_a,
  input  logic      i_alu_src_b,
  input  logic      i_reg_dst,
  input  logic      i_reg_write,
  input  logic      i_mem_read,
  input  logic      i_mem_write,
  input  logic      i_mem_to_reg,
  input  word_t     i_mem_rdata,           // Memory side
  output logic      o_exm_valid,
  output word_t     o_mem_addr,
  output word_t     o_mem_wdata,
  output logic      o_mem_read,
  output logic      o_mem_write,
  output logic      o_wb_write,            // Write-back side
  output reg_addr_t o_wb_reg,
  output word_t     o_wb_data
);

  // ID/EX outputs
  logic      de_valid, de_bubble, de_src_b, de_reg_dst;
  logic      de_reg_write, de_mem_read, de_mem_write, de_mem_to_reg;
  word_t     de_rd1, de_rd2, de_imm, de_shamt, de_next_pc;
  reg_addr_t de_rs, de_rt, de_rd;
  opcode_t   de_opcode;
  funct_t    de_funct;
  src_a_t    de_src_a;
  // Forwarding
  logic      use_fwd_a, use_fwd_b;
  word_t     fwd_a, fwd_b;
  // EX outputs
  word_t     ex_result, ex_store;
  reg_addr_t ex_reg;
  logic      ex_valid, ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg;
  // Feedback from later stages
  reg_addr_t exm_reg;
  logic      exm_write;
  word_t     exm_result;

  id_ex_reg u_id_ex_reg (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_valid (i_valid), .i_stall (i_stall), .i_flush (i_flush),
    .i_read_data_1 (i_read_data_1), .i_read_data_2 (i_read_data_2),
    .i_imm (i_imm), .i_shamt (i_shamt), .i_next_pc (i_next_pc),
    .i_rs (i_rs), .i_rt (i_rt), .i_rd (i_rd),
    .i_opcode (i_opcode), .i_funct (i_funct),
    .i_alu_src_a (i_alu_src_a), .i_alu_src_b (i_alu_src_b), .i_reg_dst (i_reg_dst),
    .i_reg_write (i_reg_write), .i_mem_read (i_mem_read),
    .i_mem_write (i_mem_write), .i_mem_to_reg (i_mem_to_reg),
    .o_valid (de_valid), .o_read_data_1 (de_rd1), .o_read_data_2 (de_rd2),
    .o_imm (de_imm), .o_shamt (de_shamt), .o_next_pc (de_next_pc),
    .o_rs (de_rs), .o_rt (de_rt), .o_rd (de_rd),
    .o_opcode (de_opcode), .o_funct (de_funct),
    .o_alu_src_a (de_src_a), .o_alu_src_b (de_src_b), .o_reg_dst (de_reg_dst),
    .o_reg_write (de_reg_write), .o_mem_read (de_mem_read),
    .o_mem_write (de_mem_write), .o_mem_to_reg (de_mem_to_reg),
    .o_stall_bubble (de_bubble)
  );

  forwarding_unit u_forwarding_unit (
    .i_rs (de_rs), .i_rt (de_rt),
    .i_exm_reg (exm_reg), .i_exm_write (exm_write), .i_exm_result (exm_result),
    .i_mwb_reg (o_wb_reg), .i_mwb_write (o_wb_write), .i_mwb_data (o_wb_data),
    .o_use_fwd_a (use_fwd_a), .o_use_fwd_b (use_fwd_b),
    .o_fwd_a (fwd_a), .o_fwd_b (fwd_b)
  );

  ex_stage u_ex_stage (
    .i_valid (de_valid), .i_stall_bubble (de_bubble),
    .i_read_data_1 (de_rd1), .i_read_data_2 (de_rd2),
    .i_imm (de_imm), .i_shamt (de_shamt), .i_next_pc (de_next_pc),
    .i_rt (de_rt), .i_rd (de_rd), .i_opcode (de_opcode), .i_funct (de_funct),
    .i_alu_src_a (de_src_a), .i_alu_src_b (de_src_b), .i_reg_dst (de_reg_dst),
    .i_reg_write (de_reg_write), .i_mem_read (de_mem_read),
    .i_mem_write (de_mem_write), .i_mem_to_reg (de_mem_to_reg),
    .i_use_fwd_a (use_fwd_a), .i_use_fwd_b (use_fwd_b),
    .i_fwd_a (fwd_a), .i_fwd_b (fwd_b),
    .o_alu_result (ex_result), .o_store_data (ex_store), .o_write_reg (ex_reg),
    .o_valid (ex_valid), .o_reg_write (ex_reg_write), .o_mem_read (ex_mem_read),
    .o_mem_write (ex_mem_write), .o_mem_to_reg (ex_mem_to_reg)
  );

  ex_mem_wb_regs u_ex_mem_wb_regs (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_valid (ex_valid), .i_alu_result (ex_result), .i_store_data (ex_store),
    .i_write_reg (ex_reg), .i_reg_write (ex_reg_write), .i_mem_read (ex_mem_read),
    .i_mem_write (ex_mem_write), .i_mem_to_reg (ex_mem_to_reg),
    .i_mem_rdata (i_mem_rdata),
    .o_exm_valid (o_exm_valid), .o_exm_reg (exm_reg), .o_exm_write (exm_write),
    .o_exm_result (exm_result), .o_mem_addr (o_mem_addr), .o_mem_wdata (o_mem_wdata),
    .o_mem_read (o_mem_read), .o_mem_write (o_mem_write),
    .o_wb_write (o_wb_write), .o_wb_reg (o_wb_reg), .o_wb_data (o_wb_data)
  );

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
  import mips_ex_pkg::*;
(
  input  logic      i_valid,
  input  logic      i_stall_bubble,        // ID/EX holds a duplicate
  input  word_t     i_read_data_1,
  input  word_t     i_read_data_2,
  input  word_t     i_imm,
  input  word_t     i_shamt,
  input  word_t     i_next_pc,
  input  reg_addr_t i_rt,
  input  reg_addr_t i_rd,
  input  opcode_t   i_opcode,
  input  funct_t    i_funct,
  input  src_a_t    i_alu_src_a,
  input  logic      i_alu_src_b,
  input  logic      i_reg_dst,
  input  logic      i_reg_write,
  input  logic      i_mem_read,
  input  logic      i_mem_write,
  input  logic      i_mem_to_reg,
  input  logic      i_use_fwd_a,           // Forwarding for rs
  input  logic      i_use_fwd_b,           // Forwarding for rt
  input  word_t     i_fwd_a,
  input  word_t     i_fwd_b,
  output word_t     o_alu_result,
  output word_t     o_store_data,          // rt for SW
  output reg_addr_t o_write_reg,
  output logic      o_valid,
  output logic      o_reg_write,
  output logic      o_mem_read,
  output logic      o_mem_write,
  output logic      o_mem_to_reg
);

  // --------------------------------------------------------------------------
  // Operand selection
  // --------------------------------------------------------------------------
  word_t   rs_val, rt_val;                 // After forwarding
  word_t   alu_a, alu_b;
  alu_op_t alu_op;
  logic    live;                           // Real, non-duplicate instruction

  assign rs_val = i_use_fwd_a ? i_fwd_a : i_read_data_1;
  assign rt_val = i_use_fwd_b ? i_fwd_b : i_read_data_2;

  always_comb begin
    case (i_alu_src_a)
      SRC_A_PC:    alu_a = i_next_pc;      // Link value
      SRC_A_SHAMT: alu_a = i_shamt;        // Constant shifts
      default:     alu_a = rs_val;
    endcase
  end

  assign alu_b = i_alu_src_b ? i_imm : rt_val;

  alu_control u_alu_control (
    .i_opcode (i_opcode),
    .i_funct  (i_funct),
    .o_alu_op (alu_op)
  );

  alu u_alu (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (alu_op),
    .o_result (o_alu_result)
  );

  // --------------------------------------------------------------------------
  // Destination and controls
  // --------------------------------------------------------------------------
  assign o_write_reg  = (i_opcode == OP_JAL) ? reg_addr_t'(31) : (i_reg_dst ? i_rd : i_rt);
  assign o_store_data = rt_val;

  assign live         = i_valid & ~i_stall_bubble;
  assign o_valid      = live;
  assign o_reg_write  = live & i_reg_write;  // Bubble never writes
  assign o_mem_read   = live & i_mem_read;
  assign o_mem_write  = live & i_mem_write;
  assign o_mem_to_reg = live & i_mem_to_reg;

endmodule

// File: design/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit
  import mips_ex_pkg::*;
(
  input  reg_addr_t i_rs,                  // Source registers in EX
  input  reg_addr_t i_rt,
  input  reg_addr_t i_exm_reg,             // EX/MEM destination
  input  logic      i_exm_write,           // Excludes loads
  input  word_t     i_exm_result,
  input  reg_addr_t i_mwb_reg,             // MEM/WB destination
  input  logic      i_mwb_write,
  input  word_t     i_mwb_data,            // ALU result or load data
  output logic      o_use_fwd_a,
  output logic      o_use_fwd_b,
  output word_t     o_fwd_a,
  output word_t     o_fwd_b
);

  logic exm_ok, mwb_ok;                    // Writer valid and not r0
  logic exm_hit_a, exm_hit_b;
  logic mwb_hit_a, mwb_hit_b;

  assign exm_ok = i_exm_write && (i_exm_reg != '0);
  assign mwb_ok = i_mwb_write && (i_mwb_reg != '0);

  assign exm_hit_a = exm_ok && (i_exm_reg == i_rs);
  assign exm_hit_b = exm_ok && (i_exm_reg == i_rt);
  assign mwb_hit_a = mwb_ok && (i_mwb_reg == i_rs);
  assign mwb_hit_b = mwb_ok && (i_mwb_reg == i_rt);

  // Younger result in EX/MEM wins
  assign o_use_fwd_a = exm_hit_a || mwb_hit_a;
  assign o_use_fwd_b = exm_hit_b || mwb_hit_b;
  assign o_fwd_a     = exm_hit_a ? i_exm_result : i_mwb_data;
  assign o_fwd_b     = exm_hit_b ? i_exm_result : i_mwb_data;

endmodule

// File: design/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg
  import mips_ex_pkg::*;
(
  input  logic      clk,
  input  logic      i_arst_n,
  input  logic      i_valid,               // Real instruction from decode
  input  logic      i_stall,               // Hold contents
  input  logic      i_flush,               // Insert bubble, beats stall
  input  word_t     i_read_data_1,         // rs value
  input  word_t     i_read_data_2,         // rt value
  input  word_t     i_imm,                 // Already extended
  input  word_t     i_shamt,               // Already extended
  input  word_t     i_next_pc,             // PC+4
  input  reg_addr_t i_rs,
  input  reg_addr_t i_rt,
  input  reg_addr_t i_rd,
  input  opcode_t   i_opcode,
  input  funct_t    i_funct,
  input  src_a_t    i_alu_src_a,
  input  logic      i_alu_src_b,           // 1 selects immediate
  input  logic      i_reg_dst,             // 1 selects rd
  input  logic      i_reg_write,
  input  logic      i_mem_read,
  input  logic      i_mem_write,
  input  logic      i_mem_to_reg,
  output logic      o_valid,
  output word_t     o_read_data_1,
  output word_t     o_read_data_2,
  output word_t     o_imm,
  output word_t     o_shamt,
  output word_t     o_next_pc,
  output reg_addr_t o_rs,
  output reg_addr_t o_rt,
  output reg_addr_t o_rd,
  output opcode_t   o_opcode,
  output funct_t    o_funct,
  output src_a_t    o_alu_src_a,
  output logic      o_alu_src_b,
  output logic      o_reg_dst,
  output logic      o_reg_write,
  output logic      o_mem_read,
  output logic      o_mem_write,
  output logic      o_mem_to_reg,
  output logic      o_stall_bubble         // Held copy already went downstream
);

  // --------------------------------------------------------------------------
  // Control bits
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid        <= 1'b0;
      o_reg_write    <= 1'b0;
      o_mem_read     <= 1'b0;
      o_mem_write    <= 1'b0;
      o_mem_to_reg   <= 1'b0;
      o_stall_bubble <= 1'b0;
    end else if (i_flush) begin              // Bubble
      o_valid        <= 1'b0;
      o_reg_write    <= 1'b0;
      o_mem_read     <= 1'b0;
      o_mem_write    <= 1'b0;
      o_mem_to_reg   <= 1'b0;
      o_stall_bubble <= 1'b0;
    end else if (i_stall) begin
      o_stall_bubble <= 1'b1;                // Contents held, mark as duplicate
    end else begin
      o_valid        <= i_valid;
      o_reg_write    <= i_valid & i_reg_write;
      o_mem_read     <= i_valid & i_mem_read;
      o_mem_write    <= i_valid & i_mem_write;
      o_mem_to_reg   <= i_valid & i_mem_to_reg;
      o_stall_bubble <= 1'b0;
    end
  end

  // Operand and field payload
  always_ff @(posedge clk) begin
    if (!i_stall) begin
      o_read_data_1 <= i_read_data_1;
      o_read_data_2 <= i_read_data_2;
      o_imm         <= i_imm;
      o_shamt       <= i_shamt;
      o_next_pc     <= i_next_pc;
      o_rs          <= i_rs;
      o_rt          <= i_rt;
      o_rd          <= i_rd;
      o_opcode      <= i_opcode;
      o_funct       <= i_funct;
      o_alu_src_a   <= i_alu_src_a;
      o_alu_src_b   <= i_alu_src_b;
      o_reg_dst     <= i_reg_dst;
    end
  end

endmodule

// File: design/mips_ex_pkg.sv
package mips_ex_pkg;

  // --------------------------------------------------------------------------
  // Datapath widths and basic types
  // --------------------------------------------------------------------------
  localparam int DATA_W     = 32;          // Word width
  localparam int REG_ADDR_W = 5;           // 32 architectural registers

  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [5:0]            opcode_t; // Instr[31:26]
  typedef logic [5:0]            funct_t;  // Instr[5:0]

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_NOR    = 4'd5,
    ALU_SLT    = 4'd6,                     // Signed compare
    ALU_SLTU   = 4'd7,                     // Unsigned compare
    ALU_SLL    = 4'd8,
    ALU_SRL    = 4'd9,
    ALU_SRA    = 4'd10,
    ALU_LUI    = 4'd11,
    ALU_PASS_A = 4'd12                     // Link value for JAL/JALR
  } alu_op_t;

  // Operand A source
  typedef enum logic [1:0] {
    SRC_A_REG   = 2'd0,                    // rs, possibly forwarded
    SRC_A_PC    = 2'd1,                    // PC+4
    SRC_A_SHAMT = 2'd2                     // Extended shamt
  } src_a_t;

  // --------------------------------------------------------------------------
  // Opcode and function codes
  // --------------------------------------------------------------------------
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_SLTI  = 6'h0a;
  localparam opcode_t OP_SLTIU = 6'h0b;
  localparam opcode_t OP_ANDI  = 6'h0c;
  localparam opcode_t OP_ORI   = 6'h0d;
  localparam opcode_t OP_XORI  = 6'h0e;
  localparam opcode_t OP_LUI   = 6'h0f;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  localparam funct_t FN_SLL  = 6'h00;
  localparam funct_t FN_SRL  = 6'h02;
  localparam funct_t FN_SRA  = 6'h03;
  localparam funct_t FN_SLLV = 6'h04;
  localparam funct_t FN_SRLV = 6'h06;
  localparam funct_t FN_SRAV = 6'h07;
  localparam funct_t FN_JALR = 6'h09;
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_XOR  = 6'h26;
  localparam funct_t FN_NOR  = 6'h27;
  localparam funct_t FN_SLT  = 6'h2a;
  localparam funct_t FN_SLTU = 6'h2b;

endpackage

// File: ex_pipe_top.f
design/mips_ex_pkg.sv
design/alu_control.sv
design/alu.sv
design/forwarding_unit.sv
design/id_ex_reg.sv
design/ex_stage.sv
design/ex_mem_wb_regs.sv
design/ex_pipe_top.sv
sim/tb_ex_pipe_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the EX pipeline testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timescale 1ns/1ps --top-module tb_ex_pipe_top -f ex_pipe_top.f \
  -o tb_ex_pipe_top > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_ex_pipe_top > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "No pass line found in sim.log"; exit 1; }
echo "Simulation passed"

// File: sim/tb_ex_pipe_top.sv
`timescale 1ns/1ps

module tb_ex_pipe_top
  import mips_ex_pkg::*;
;

  localparam int    CLK_NS     = 8;
  localparam int    RST_CYCLES = 8;
  localparam int    N_INSTR    = 400;                  // Issued instructions
  localparam word_t LOAD_XOR   = 32'h5a5a_0000;        // Memory model pattern
  localparam funct_t  RFUNCT [15] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
    FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JALR};
  localparam opcode_t IOPS [10] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
    OP_SLTIU, OP_LUI, OP_LW, OP_SW, OP_JAL};

  // One instruction as seen by the pipeline model
  typedef struct packed {
    logic      live;                                   // Real instruction
    logic      dup;                                    // Held copy in ID/EX
    logic      wr;
    logic      ld;
    logic      st;
    reg_addr_t dst;
    word_t     res;                                    // ALU result or address
    word_t     val;                                    // Write-back value
    word_t     sdata;                                  // Store data
  } slot_t;

  logic      clk, i_arst_n, i_valid, i_stall, i_flush;
  word_t     i_read_data_1, i_read_data_2, i_imm, i_shamt, i_next_pc;
  reg_addr_t i_rs, i_rt, i_rd;
  opcode_t   i_opcode;
  funct_t    i_funct;
  src_a_t    i_alu_src_a;
  logic      i_alu_src_b, i_reg_dst, i_reg_write, i_mem_read, i_mem_write, i_mem_to_reg;
  word_t     i_mem_rdata, o_mem_addr, o_mem_wdata, o_wb_data;
  logic      o_exm_valid, o_mem_read, o_mem_write, o_wb_write;
  reg_addr_t o_wb_reg;

  logic [31:0] lfsr = 32'h4fdc;
  word_t       arch [32];                              // Reference register state
  word_t       rf_commit [32];                         // Written-back registers only
  slot_t       idex = '0, exm = '0, mwb = '0;          // Pipeline model
  slot_t       cur;                                    // Instruction on the inputs
  logic        cur_stall, cur_flush, cur_issue;
  slot_t       wbq [$];                                // Expected write-backs
  int          issued = 0;

  ex_pipe_top u_dut (.*);

  assign i_mem_rdata = o_mem_addr ^ LOAD_XOR;          // Combinational memory

  always #(CLK_NS / 2) clk = ~clk;

  // --------------------------------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic word_t ref_result(opcode_t op, funct_t fn, word_t a, word_t b,
                                       word_t imm, word_t sh, word_t npc);
    if (op == OP_RTYPE) begin
      case (fn)
        FN_ADDU: return a + b;
        FN_SUBU: return a - b;
        FN_AND:  return a & b;
        FN_OR:   return a | b;
        FN_XOR:  return a ^ b;
        FN_NOR:  return ~(a | b);
        FN_SLT:  return word_t'($signed(a) < $signed(b));
        FN_SLTU: return word_t'(a < b);
        FN_SLL:  return b << sh[4:0];                  // Constant shifts
        FN_SRL:  return b >> sh[4:0];
        FN_SRA:  return word_t'($signed(b) >>> sh[4:0]);
        FN_SLLV: return b << a[4:0];                   // Amount from rs
        FN_SRLV: return b >> a[4:0];
        FN_SRAV: return word_t'($signed(b) >>> a[4:0]);
        default: return npc;                           // JALR link
      endcase
    end
    case (op)
      OP_ANDI:  return a & imm;
      OP_ORI:   return a | imm;
      OP_XORI:  return a ^ imm;
      OP_SLTI:  return word_t'($signed(a) < $signed(imm));
      OP_SLTIU: return word_t'(a < imm);
      OP_LUI:   return {imm[15:0], 16'h0000};
      OP_JAL:   return npc;
      default:  return a + imm;                        // ADDIU, LW, SW
    endcase
  endfunction

  // Register file read port with write-through of the value now in MEM/WB
  function automatic word_t read_port(reg_addr_t r);
    if (r == '0) return '0;
    if (mwb.live && mwb.wr && mwb.dst == r) return mwb.val;
    return rf_commit[r];
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic make_instr(output slot_t s);
    int          kind;
    logic [15:0] imm16;
    logic        rtype;
    kind  = int'(take_bits(5)) % 25;
    rtype = kind < 15;
    imm16 = 16'(take_bits(16));
    i_rs  = reg_addr_t'(take_bits(3));                 // r0..r7 for lots of overlap
    i_rt  = reg_addr_t'(take_bits(3));
    i_rd  = reg_addr_t'(take_bits(3));
    i_shamt   = take_bits(5);
    i_next_pc = take_bits(32) & 32'hffff_fffc;
    i_opcode  = rtype ? OP_RTYPE : IOPS[kind-15];
    i_funct   = rtype ? RFUNCT[kind] : funct_t'(take_bits(6));
    i_imm     = (kind >= 16 && kind <= 18) ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
    i_alu_src_a  = (kind >= 8 && kind <= 10) ? SRC_A_SHAMT :
                   (kind == 14 || kind == 24) ? SRC_A_PC : SRC_A_REG;
    i_alu_src_b  = !rtype;
    i_reg_dst    = rtype;
    i_reg_write  = (kind != 23);                       // All but SW
    i_mem_read   = (kind == 22);
    i_mem_to_reg = (kind == 22);
    i_mem_write  = (kind == 23);
    i_read_data_1 = read_port(i_rs);
    i_read_data_2 = read_port(i_rt);
    s       = '0;
    s.live  = 1'b1;
    s.wr    = i_reg_write;
    s.ld    = i_mem_read;
    s.st    = i_mem_write;
    s.dst   = (kind == 24) ? reg_addr_t'(31) : (rtype ? i_rd : i_rt);  // JAL links r31
    s.res   = ref_result(i_opcode, i_funct, arch[i_rs], arch[i_rt], i_imm, i_shamt,
                         i_next_pc);
    s.val   = s.ld ? (s.res ^ LOAD_XOR) : s.res;
    s.sdata = arch[i_rt];
  endtask

  task automatic drive_cycle();
    int r;
    r = int'(take_bits(4));
    cur_stall = (idex.live && !idex.dup && idex.ld) || (r == 0);  // Load-use or random
    cur_flush = !cur_stall && (r == 1);
    make_instr(cur);                                   // Junk when not issued
    i_valid   = (r != 2);                              // Idle gap
    i_stall   = cur_stall;
    i_flush   = cur_flush;
    cur_issue = i_valid && !cur_stall && !cur_flush;
  endtask

  // Model of one clock edge on the inputs just sampled
  task automatic advance_model();
    if (mwb.live && mwb.wr && mwb.dst != '0) rf_commit[mwb.dst] = mwb.val;
    mwb = exm;
    exm = (idex.live && !idex.dup) ? idex : '0;
    if (cur_flush) begin
      idex = '0;
    end else if (cur_stall) begin
      idex.dup = 1'b1;                                 // Already went downstream
    end else if (cur_issue) begin
      idex = cur;
      if (cur.wr && cur.dst != '0) arch[cur.dst] = cur.val;
      if (cur.wr) wbq.push_back(cur);
      issued++;
    end else begin
      idex = '0;
    end
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("ERROR %s (instr %0d): expected %h actual %h", name, issued, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_reg(string name, reg_addr_t exp, reg_addr_t act);
    if (act !== exp) begin
      $display("ERROR %s (instr %0d): expected %0d actual %0d", name, issued, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERROR %s (instr %0d): expected %b actual %b", name, issued, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic compare_cycle();
    slot_t e;
    check_bit("exm_valid", exm.live, o_exm_valid);
    check_bit("mem_read", exm.live & exm.ld, o_mem_read);
    check_bit("mem_write", exm.live & exm.st, o_mem_write);
    if (exm.live && (exm.ld || exm.st)) check_word("mem_addr", exm.res, o_mem_addr);
    if (exm.live && exm.st) check_word("mem_wdata", exm.sdata, o_mem_wdata);
    if (o_wb_write === 1'b1 && wbq.size() == 0) begin
      $display("Write-back to register %0d when no instruction was waiting for one",
               o_wb_reg);
      stop_on_failure();
    end
    check_bit("wb_write", mwb.live & mwb.wr, o_wb_write);
    if (o_wb_write === 1'b1) begin
      e = wbq.pop_front();
      check_reg("wb_reg", e.dst, o_wb_reg);
      check_word("wb_data", e.val, o_wb_data);
    end
  endtask

  // Compare at the falling edge where outputs are settled
  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      compare_cycle();
    end
  end

  initial begin
    #(CLK_NS * (RST_CYCLES + N_INSTR * 10));
    $display("Watchdog expired before all %0d instructions completed", N_INSTR);
    stop_on_failure();
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    i_arst_n = 1'b0;
    {i_valid, i_stall, i_flush, i_alu_src_b, i_reg_dst} = '0;
    {i_reg_write, i_mem_read, i_mem_write, i_mem_to_reg} = '0;
    {i_read_data_1, i_read_data_2, i_imm, i_shamt, i_next_pc} = '0;
    {i_rs, i_rt, i_rd, i_opcode, i_funct} = '0;
    i_alu_src_a = SRC_A_REG;
    {cur_stall, cur_flush, cur_issue} = '0;
    cur = '0;
    for (int i = 0; i < 32; i++) begin
      arch[i]      = (i == 0) ? '0 : take_bits(32);    // Random initial registers
      rf_commit[i] = arch[i];
    end
    repeat (RST_CYCLES) @(posedge clk);
    #1 i_arst_n = 1'b1;
    while (issued < N_INSTR) begin
      drive_cycle();
      @(posedge clk);
      #1;
      advance_model();
    end
    {i_valid, i_stall, i_flush, cur_stall, cur_flush, cur_issue} = '0;
    repeat (4) begin                                   // Drain the pipeline
      @(posedge clk);
      #1;
      advance_model();
    end
    if (wbq.size() != 0) begin
      $display("%0d expected write-backs never appeared", wbq.size());
      stop_on_failure();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule
